/* logic/opl_defines.svh */
// ----------------------------------------------------------------------
// register addresses and timing ratios for the timer section
// ----------------------------------------------------------------------
`ifndef OPL_DEFINES_SVH
`define OPL_DEFINES_SVH

// register map, selected through a write with addr 0
// timer A preset
`define OPL_REG_CLKA    8'h02
// timer B preset
`define OPL_REG_CLKB    8'h03
// start bits and flag clears
`define OPL_REG_TIMER   8'h04

// cen pulses per cen16 tick
`define OPL_CEN_DIV     16

// cen16 ticks per timer B count
`define OPL_TB_PRESCALE 4

`endif

/* logic/opl_pkg.sv */
// ----------------------------------------------------------------------
// types shared by the register file, the timers and the top level
// ----------------------------------------------------------------------
package opl_pkg;

    // register file steering of both timers
    typedef struct packed {
        logic [7:0] value_a;
        logic [7:0] value_b;
        logic       load_a;
        logic       load_b;
        logic       clr_flag_a;
        logic       clr_flag_b;
    } opl_timer_cfg_t;

    // flags and the combined interrupt
    typedef struct packed {
        logic irq;
        logic flag_b;
        logic flag_a;
    } opl_status_t;

    // bit layout of a byte written to the timer control register
    typedef struct packed {
        logic       irq_rst;
        logic       clr_a;
        logic       clr_b;
        logic [2:0] unused;
        logic       load_b;
        logic       load_a;
    } opl_timer_ctrl_t;

    // data byte, either a whole preset or control bits
    typedef union packed {
        logic [7:0]       raw;
        opl_timer_ctrl_t  ctrl;
    } opl_wr_data_u;

endpackage

/* logic/opl_clk_div.sv */
// ----------------------------------------------------------------------
// clock-enable divider, cen in and one cen16 tick per 16 cen pulses
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "opl_defines.svh"

module opl_clk_div (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic cen16
);

    localparam int unsigned DIV_W = $clog2(`OPL_CEN_DIV);
    // count value of the last cen pulse before the wrap
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`OPL_CEN_DIV - 1);

    // cen pulses seen since the last tick
    logic [DIV_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            cen16 <= 1'b0;
        end else begin
            // tick is a single clk cycle wide
            cen16 <= 1'b0;
            if (cen) begin
                if (cnt == DIV_LAST) begin
                    cnt   <= '0;
                    // registered, so it shows the cycle after the last pulse
                    cen16 <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* logic/opl_mmr.sv */
// ----------------------------------------------------------------------
// register-select latch and register file steering both timers
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "opl_defines.svh"

module opl_mmr (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen16,
    input  logic [7:0]               din,
    input  logic                     addr,
    input  logic                     write,
    output opl_pkg::opl_timer_cfg_t  cfg
);

    import opl_pkg::*;

    // register picked by the last address write
    logic [7:0] sel_reg;

    // same byte, seen as a value or as control bits
    opl_wr_data_u wr_data;

    // data phase write and its target
    logic wr_data_en;
    logic wr_clka;
    logic wr_clkb;
    logic wr_timer;

    assign wr_data.raw = din;

    // addr 1 carries data for the selected register
    assign wr_data_en = write & addr;

    assign wr_clka  = wr_data_en & (sel_reg == `OPL_REG_CLKA);
    assign wr_clkb  = wr_data_en & (sel_reg == `OPL_REG_CLKB);
    assign wr_timer = wr_data_en & (sel_reg == `OPL_REG_TIMER);

    // address phase
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg <= 8'h00;
        end else if (write && !addr) begin
            sel_reg <= din;
        end
    end

    // presets, plain byte values
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.value_a <= 8'h00;
            cfg.value_b <= 8'h00;
        end else begin
            if (wr_clka) begin
                cfg.value_a <= wr_data.raw;
            end
            if (wr_clkb) begin
                cfg.value_b <= wr_data.raw;
            end
        end
    end

    // start bits follow every control write
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.load_a <= 1'b0;
            cfg.load_b <= 1'b0;
        end else if (wr_timer) begin
            // bit 7 does not matter here
            cfg.load_a <= wr_data.ctrl.load_a;
            cfg.load_b <= wr_data.ctrl.load_b;
        end
    end

    // flag clears, once-only bits
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.clr_flag_a <= 1'b0;
            cfg.clr_flag_b <= 1'b0;
        end else if (write) begin
            // clear bits act only with bit 7 set
            if (wr_timer && wr_data.ctrl.irq_rst) begin
                cfg.clr_flag_a <= wr_data.ctrl.clr_a;
                cfg.clr_flag_b <= wr_data.ctrl.clr_b;
            end
        end else if (cen16) begin
            // held until a tick with no write on the port
            cfg.clr_flag_a <= 1'b0;
            cfg.clr_flag_b <= 1'b0;
        end
    end

endmodule

/* logic/opl_timers.sv */
// ----------------------------------------------------------------------
// timers A and B, timer B prescaler, overflow flags and irq
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "opl_defines.svh"

module opl_timers (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen16,
    input  opl_pkg::opl_timer_cfg_t  cfg,
    output opl_pkg::opl_status_t     status
);

    localparam int unsigned PRE_W = $clog2(`OPL_TB_PRESCALE);
    // prescaler value on the tick that advances timer B
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`OPL_TB_PRESCALE - 1);

    // up counters
    logic [7:0] cnt_a;
    logic [7:0] cnt_b;

    // timer B tick divider
    logic [PRE_W-1:0] presc_b;

    // load bits one cycle back, for start detection
    logic load_a_l;
    logic load_b_l;

    // sticky flags before the clear mask
    logic flag_a_q;
    logic flag_b_q;

    // start edges, count steps and overflows
    logic start_a;
    logic start_b;
    logic step_a;
    logic step_b;
    logic ovf_a;
    logic ovf_b;

    assign start_a = cfg.load_a & ~load_a_l;
    assign start_b = cfg.load_b & ~load_b_l;

    // a start takes the cycle, counting resumes on the next tick
    assign step_a = cen16 & cfg.load_a & ~start_a;
    assign step_b = cen16 & cfg.load_b & ~start_b & (presc_b == PRE_LAST);

    // would pass 255
    assign ovf_a = step_a & (cnt_a == 8'hff);
    assign ovf_b = step_b & (cnt_b == 8'hff);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_a_l <= 1'b0;
            load_b_l <= 1'b0;
        end else begin
            load_a_l <= cfg.load_a;
            load_b_l <= cfg.load_b;
        end
    end

    // timer A
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a <= 8'h00;
        end else if (start_a || ovf_a) begin
            // preset copy on start and reload on overflow
            cnt_a <= cfg.value_a;
        end else if (step_a) begin
            cnt_a <= cnt_a + 8'd1;
        end
    end

    // timer B prescaler, restarted by the start edge
    always_ff @(posedge clk) begin
        if (rst) begin
            presc_b <= '0;
        end else if (start_b) begin
            presc_b <= '0;
        end else if (cen16 && cfg.load_b) begin
            if (presc_b == PRE_LAST) begin
                presc_b <= '0;
            end else begin
                presc_b <= presc_b + 1'b1;
            end
        end
    end

    // timer B
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_b <= 8'h00;
        end else if (start_b || ovf_b) begin
            cnt_b <= cfg.value_b;
        end else if (step_b) begin
            cnt_b <= cnt_b + 8'd1;
        end
    end

    // flags, clearing wins over a same-cycle overflow
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a_q <= 1'b0;
            flag_b_q <= 1'b0;
        end else begin
            if (cfg.clr_flag_a) begin
                flag_a_q <= 1'b0;
            end else if (ovf_a) begin
                flag_a_q <= 1'b1;
            end
            if (cfg.clr_flag_b) begin
                flag_b_q <= 1'b0;
            end else if (ovf_b) begin
                flag_b_q <= 1'b1;
            end
        end
    end

    // masked so a flag reads 0 for as long as its clear is high
    assign status.flag_a = flag_a_q & ~cfg.clr_flag_a;
    assign status.flag_b = flag_b_q & ~cfg.clr_flag_b;
    assign status.irq    = status.flag_a | status.flag_b;

endmodule

/* logic/opl_timer_top.sv */
// ----------------------------------------------------------------------
// timer section top, divider plus register file plus timers
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module opl_timer_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic [7:0]            din,
    input  logic                  addr,
    input  logic                  write,
    output logic                  cen16,
    output opl_pkg::opl_status_t  status
);

    import opl_pkg::*;

    // register file to timers
    opl_timer_cfg_t cfg;

    // slow time base, also brought out for observation
    opl_clk_div opl_clk_div_inst (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .cen16 (cen16)
    );

    // host port decode
    opl_mmr opl_mmr_inst (
        .clk   (clk),
        .rst   (rst),
        .cen16 (cen16),
        .din   (din),
        .addr  (addr),
        .write (write),
        .cfg   (cfg)
    );

    opl_timers opl_timers_inst (
        .clk    (clk),
        .rst    (rst),
        .cen16  (cen16),
        .cfg    (cfg),
        .status (status)
    );

endmodule

/* verification/opl_timer_tb.sv */
// ----------------------------------------------------------------------
// timer section testbench with lcg stimulus and a cycle model of both timers
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "opl_defines.svh"

module opl_timer_tb;

    import opl_pkg::*;

    // dut ports
    logic        clk;
    logic        rst;
    logic        cen;
    logic [7:0]  din;
    logic        addr;
    logic        write;
    logic        cen16;
    opl_status_t status;

    // stimulus generator state
    logic [31:0] rng;

    // bookkeeping
    string test_name;
    int    checks;
    int    model_errors;
    int    test_errors;
    int    tick_count;
    logic  cen16_prev;

    // model state as held during the current cycle
    int         m_div;
    logic       m_cen16;
    logic [7:0] m_sel;
    logic [7:0] m_val_a;
    logic [7:0] m_val_b;
    logic       m_load_a;
    logic       m_load_b;
    logic       m_run_a;
    logic       m_run_b;
    logic       m_clr_a;
    logic       m_clr_b;
    logic [7:0] m_cnt_a;
    logic [7:0] m_cnt_b;
    int         m_pre_b;
    logic       m_flag_a;
    logic       m_flag_b;

    opl_timer_top opl_timer_top_inst (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .din    (din),
        .addr   (addr),
        .write  (write),
        .cen16  (cen16),
        .status (status)
    );

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one clock cycle with cen high about half the time
    task automatic step_cycle(input logic allow_cen);
        rng = lcg_next(rng);
        cen = allow_cen & rng[16];
        @(negedge clk);
    endtask

    // single write strobe that returns in the cycle after its sampling edge
    task automatic host_write(input logic a, input logic [7:0] d);
        write = 1'b1;
        addr  = a;
        din   = d;
        step_cycle(1'b1);
        write = 1'b0;
    endtask

    // status bit index 0 is flag_a, 1 is flag_b and 2 is irq
    task automatic wait_status(input int bit_idx, input int max_cycles, output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < max_cycles) begin
            if (status[bit_idx]) begin
                seen = 1'b1;
            end else begin
                step_cycle(1'b1);
                n++;
            end
        end
        if (!seen) begin
            test_errors++;
            $display("%s: timed out waiting for status bit %0d to rise", test_name, bit_idx);
        end
    endtask

    // no flag may rise while the timers are stopped
    task automatic expect_quiet(input int cycles);
        int   n;
        logic bad;
        bad = 1'b0;
        for (n = 0; n < cycles; n++) begin
            step_cycle(1'b1);
            if (!bad && status !== 3'b000) begin
                bad = 1'b1;
                test_errors++;
                $display("Error %s: expected %b, actual %b", test_name, 3'b000, status);
            end
        end
    endtask

    // reference model steps from this cycle's inputs and registers
    always @(posedge clk) begin : model_update
        logic begin_a;
        logic begin_b;
        logic wrap_a;
        logic wrap_b;
        if (rst) begin
            m_div    = 0;
            m_cen16  = 1'b0;
            m_sel    = 8'h00;
            m_val_a  = 8'h00;
            m_val_b  = 8'h00;
            m_load_a = 1'b0;
            m_load_b = 1'b0;
            m_run_a  = 1'b0;
            m_run_b  = 1'b0;
            m_clr_a  = 1'b0;
            m_clr_b  = 1'b0;
            m_cnt_a  = 8'h00;
            m_cnt_b  = 8'h00;
            m_pre_b  = 0;
            m_flag_a = 1'b0;
            m_flag_b = 1'b0;
            tick_count = 0;
        end else begin
            if (m_cen16) begin
                tick_count++;
            end
            // timers see the registers of this cycle
            begin_a = m_load_a && !m_run_a;
            begin_b = m_load_b && !m_run_b;
            wrap_a  = 1'b0;
            wrap_b  = 1'b0;
            if (begin_a) begin
                m_cnt_a = m_val_a;
            end else if (m_cen16 && m_load_a) begin
                if (m_cnt_a == 8'hff) begin
                    m_cnt_a = m_val_a;
                    wrap_a  = 1'b1;
                end else begin
                    m_cnt_a = m_cnt_a + 8'd1;
                end
            end
            // timer B moves on every fourth tick after its start
            if (begin_b) begin
                m_cnt_b = m_val_b;
                m_pre_b = 0;
            end else if (m_cen16 && m_load_b) begin
                m_pre_b++;
                if (m_pre_b == `OPL_TB_PRESCALE) begin
                    m_pre_b = 0;
                    if (m_cnt_b == 8'hff) begin
                        m_cnt_b = m_val_b;
                        wrap_b  = 1'b1;
                    end else begin
                        m_cnt_b = m_cnt_b + 8'd1;
                    end
                end
            end
            // clear beats overflow
            if (m_clr_a) begin
                m_flag_a = 1'b0;
            end else if (wrap_a) begin
                m_flag_a = 1'b1;
            end
            if (m_clr_b) begin
                m_flag_b = 1'b0;
            end else if (wrap_b) begin
                m_flag_b = 1'b1;
            end
            m_run_a = m_load_a;
            m_run_b = m_load_b;
            // register map
            if (write) begin
                if (!addr) begin
                    m_sel = din;
                end else if (m_sel == `OPL_REG_CLKA) begin
                    m_val_a = din;
                end else if (m_sel == `OPL_REG_CLKB) begin
                    m_val_b = din;
                end else if (m_sel == `OPL_REG_TIMER) begin
                    m_load_a = din[0];
                    m_load_b = din[1];
                    if (din[7]) begin
                        m_clr_a = din[6];
                        m_clr_b = din[5];
                    end
                end
            end else if (m_cen16) begin
                m_clr_a = 1'b0;
                m_clr_b = 1'b0;
            end
            // tick in the cycle after the 16th cen
            m_cen16 = 1'b0;
            if (cen) begin
                m_div++;
                if (m_div == `OPL_CEN_DIV) begin
                    m_div   = 0;
                    m_cen16 = 1'b1;
                end
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin : compare_outputs
        opl_status_t exp_status;
        if (!rst) begin
            exp_status.flag_a = m_flag_a & ~m_clr_a;
            exp_status.flag_b = m_flag_b & ~m_clr_b;
            exp_status.irq    = exp_status.flag_a | exp_status.flag_b;
            checks++;
            if (cen16 !== m_cen16) begin
                model_errors++;
                $display("Error %s: cen16 expected %b, actual %b", test_name, m_cen16, cen16);
            end
            if (status !== exp_status) begin
                model_errors++;
                $display("Error %s: status expected %b, actual %b",
                         test_name, exp_status, status);
            end
            if (cen16 && cen16_prev) begin
                model_errors++;
                $display("%s: cen16 stayed high for more than one cycle", test_name);
            end
            cen16_prev = cen16;
        end
    end

    initial begin : main
        logic [7:0] preset;
        int         exp_ticks;
        int         t0;
        int         pulses;
        int         seen16;
        int         i;
        logic       ok;
        rst   = 1'b1;
        cen   = 1'b0;
        din   = 8'h00;
        addr  = 1'b0;
        write = 1'b0;
        rng   = 32'h9faf;
        checks       = 0;
        model_errors = 0;
        test_errors  = 0;
        cen16_prev   = 1'b0;
        test_name    = "reset";
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle after reset with the divider counting from zero
        test_name = "reset_divider";
        pulses = 0;
        seen16 = 0;
        for (i = 0; i < 200; i++) begin
            step_cycle(1'b1);
            if (cen) begin
                pulses++;
            end
            if (cen16) begin
                seen16++;
            end
            if (status !== 3'b000) begin
                test_errors++;
                $display("Error %s: expected %b, actual %b", test_name, 3'b000, status);
            end
        end
        repeat (2) begin
            step_cycle(1'b0);
            if (cen16) begin
                seen16++;
            end
        end
        if (seen16 != pulses / `OPL_CEN_DIV) begin
            test_errors++;
            $display("Error %s: expected %0d, actual %0d",
                     test_name, pulses / `OPL_CEN_DIV, seen16);
        end

        // timer A period from the start and again after a clear
        test_name = "timer_a";
        rng = lcg_next(rng);
        preset = 8'hc0 + 8'(rng[23:16] % 60);
        exp_ticks = 256 - int'(preset);
        host_write(1'b0, `OPL_REG_CLKA);
        host_write(1'b1, preset);
        host_write(1'b0, `OPL_REG_TIMER);
        host_write(1'b1, 8'h01);
        step_cycle(1'b1);
        t0 = tick_count;
        wait_status(0, exp_ticks * 64 + 200, ok);
        if (ok && tick_count - t0 != exp_ticks) begin
            test_errors++;
            $display("Error %s: expected %0d, actual %0d", test_name, exp_ticks, tick_count - t0);
        end
        if (ok && !status.irq) begin
            test_errors++;
            $display("Error %s: expected %b, actual %b", test_name, 1'b1, status.irq);
        end
        t0 = tick_count;
        host_write(1'b1, 8'hc1);
        if (status.flag_a !== 1'b0) begin
            test_errors++;
            $display("Error %s: expected %b, actual %b", test_name, 1'b0, status.flag_a);
        end
        wait_status(0, exp_ticks * 64 + 200, ok);
        if (ok && tick_count - t0 != exp_ticks) begin
            test_errors++;
            $display("Error %s: expected %0d, actual %0d", test_name, exp_ticks, tick_count - t0);
        end
        host_write(1'b1, 8'h00);
        host_write(1'b1, 8'he0);

        // timer B counts once per four ticks
        test_name = "timer_b";
        rng = lcg_next(rng);
        preset = 8'hf0 + 8'(rng[23:16] % 12);
        exp_ticks = `OPL_TB_PRESCALE * (256 - int'(preset));
        host_write(1'b0, `OPL_REG_CLKB);
        host_write(1'b1, preset);
        host_write(1'b0, `OPL_REG_TIMER);
        host_write(1'b1, 8'h02);
        step_cycle(1'b1);
        t0 = tick_count;
        wait_status(1, exp_ticks * 64 + 200, ok);
        if (ok && tick_count - t0 != exp_ticks) begin
            test_errors++;
            $display("Error %s: expected %0d, actual %0d", test_name, exp_ticks, tick_count - t0);
        end
        t0 = tick_count;
        host_write(1'b1, 8'ha2);
        wait_status(1, exp_ticks * 64 + 200, ok);
        if (ok && tick_count - t0 != exp_ticks) begin
            test_errors++;
            $display("Error %s: expected %0d, actual %0d", test_name, exp_ticks, tick_count - t0);
        end
        host_write(1'b1, 8'h00);
        host_write(1'b1, 8'he0);

        // with both running a clear acts only with bit 7
        test_name = "flag_clear";
        host_write(1'b1, 8'h03);
        wait_status(0, 8000, ok);
        wait_status(1, 8000, ok);
        host_write(1'b1, 8'h43);
        if (status !== 3'b111) begin
            test_errors++;
            $display("Error %s: expected %b, actual %b", test_name, 3'b111, status);
        end
        host_write(1'b1, 8'hc3);
        if (status !== 3'b110) begin
            test_errors++;
            $display("Error %s: expected %b, actual %b", test_name, 3'b110, status);
        end
        // flag_a gone and flag_b masked, so irq drops too
        host_write(1'b1, 8'ha3);
        if (status !== 3'b000) begin
            test_errors++;
            $display("Error %s: expected %b, actual %b", test_name, 3'b000, status);
        end
        host_write(1'b1, 8'he0);
        if (status !== 3'b000) begin
            test_errors++;
            $display("Error %s: expected %b, actual %b", test_name, 3'b000, status);
        end

        // unmapped register and stopped timers
        test_name = "register_map";
        host_write(1'b0, `OPL_REG_CLKA);
        host_write(1'b1, 8'hff);
        host_write(1'b0, 8'h05);
        host_write(1'b1, 8'h03);
        host_write(1'b0, 8'h01);
        host_write(1'b1, 8'hff);
        expect_quiet(1500);

        // random traffic checked against the model every cycle
        test_name = "random";
        for (i = 0; i < 400; i++) begin
            rng = lcg_next(rng);
            case (rng[18:16])
                3'd4: host_write(1'b0, 8'h02 + {6'b0, rng[25:24]});
                3'd5, 3'd6: host_write(1'b1, rng[31:24]);
                default: step_cycle(1'b1);
            endcase
        end

        $display("checks %0d, model errors %0d, test errors %0d",
                 checks, model_errors, test_errors);
        if (model_errors == 0 && test_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+logic
logic/opl_pkg.sv
logic/opl_clk_div.sv
logic/opl_mmr.sv
logic/opl_timers.sv
logic/opl_timer_top.sv
verification/opl_timer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the timer section testbench with Verilator and run it

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=opl_timer_sim
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal \
    -f tb.f \
    --top-module opl_timer_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# verdict comes from the log only
if grep -qx "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
exit 1
